// File: all.f
+incdir+rtl
rtl/sl_pkg.sv
rtl/obi_phase_monitor.sv
rtl/req_attribute_fifo.sv
rtl/retire_event_tracker.sv
rtl/support_logic_top.sv
verification/tb_support_logic.sv

// File: rtl/obi_phase_monitor.sv
// ---------------------------------------------------------------------
// watches req, gnt and rvalid of one OBI bus and reports stalled
// address phases, pending responses and the outstanding count
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sl_macros.svh"

module obi_phase_monitor (
  input  wire logic                in_support_if,
  input  wire logic                reset_i,
  input  wire sl_pkg::obi_bus_t    bus_i,
  output sl_pkg::bus_status_t      status_o
);

  localparam int CNT_W = `SL_CNT_W;
  localparam int DEPTH = `SL_FIFO_DEPTH;

  // address phase was stalled in the previous cycle
  logic             stall_q;
  logic [CNT_W-1:0] outstanding_q;
  logic             grant;
  logic             response;

  assign grant    = bus_i.req && bus_i.gnt;
  assign response = bus_i.rvalid;

  // -------------------------------------------------------------------
  // stall flag and outstanding counter
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      stall_q       <= 1'b0;
      outstanding_q <= '0;
    end else begin
      stall_q <= bus_i.req && !bus_i.gnt;

      // grant and response together leave the count as it is
      if (grant && !response) begin
        if (outstanding_q != CNT_W'(DEPTH)) begin
          outstanding_q <= outstanding_q + 1'b1;
        end
      end else if (response && !grant) begin
        if (outstanding_q != '0) begin
          outstanding_q <= outstanding_q - 1'b1;
        end
      end
    end
  end

  // -------------------------------------------------------------------
  // status outputs
  // -------------------------------------------------------------------
  always_comb begin
    status_o.addr_ph_cont = stall_q;
    // still waiting on at least one response
    status_o.resp_ph_cont = (outstanding_q != '0) && !bus_i.rvalid;
    status_o.outstanding  = outstanding_q;
  end

endmodule : obi_phase_monitor

`default_nettype wire

// File: rtl/req_attribute_fifo.sv
// ---------------------------------------------------------------------
// keeps one attribute per granted OBI request and shows it alongside
// the matching response; the payload type is set per instance
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sl_macros.svh"

module req_attribute_fifo #(
  parameter type attr_t = logic
) (
  input  wire logic             in_support_if,
  input  wire logic             reset_i,
  input  wire sl_pkg::obi_bus_t bus_i,
  input  wire attr_t            attr_i,
  output attr_t                 attr_o
);

  localparam int DEPTH = `SL_FIFO_DEPTH;
  localparam int CNT_W = `SL_CNT_W;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  attr_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  // a grant past a full buffer is dropped
  assign push = bus_i.req && bus_i.gnt && !full;
  assign pop  = bus_i.rvalid && !empty;

  // -------------------------------------------------------------------
  // storage
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q] <= attr_i;
    end
  end

  // -------------------------------------------------------------------
  // pointers and fill level
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // oldest attribute during a response, zero otherwise
  assign attr_o = pop ? mem[rd_ptr_q] : attr_t'('0);

endmodule : req_attribute_fifo

`default_nettype wire

// File: rtl/retire_event_tracker.sv
// ---------------------------------------------------------------------
// derives debug, startup, debug request and post-trap bus events from
// the retirement stream, the trap redirect and the data bus handshake
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sl_macros.svh"

module retire_event_tracker (
  input  wire logic               in_support_if,
  input  wire logic               reset_i,
  input  wire sl_pkg::retire_t    retire_i,
  input  wire sl_pkg::trap_evt_t  trap_i,
  input  wire logic               fetch_enable_i,
  input  wire logic               debug_req_i,
  input  wire sl_pkg::obi_bus_t   data_bus_i,
  output sl_pkg::retire_events_t  events_o
);

  import sl_pkg::*;

  localparam int HOLD   = `SL_DBG_HOLD;
  localparam int HOLD_W = $clog2(HOLD + 2);

  retire_events_t    events;
  logic              dbg_flag_q;
  logic              dret_pending_q;
  logic              fetch_enable_q;
  logic              rec_dbg_req_q;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic              exception_active_q;
  logic              data_gnt_q;
  logic              req_after_exc_q;

  // -------------------------------------------------------------------
  // debug episode, cleared one cycle after a dret that did not trap
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      dbg_flag_q     <= 1'b0;
      dret_pending_q <= 1'b0;
    end else begin
      if (retire_i.valid) begin
        dbg_flag_q <= retire_i.dbg_mode;
        if (retire_i.is_dret && !retire_i.trap) begin
          dret_pending_q <= 1'b1;
        end
      end
      if (dret_pending_q) begin
        dbg_flag_q     <= 1'b0;
        dret_pending_q <= 1'b0;
      end
    end
  end

  // sticky once fetch has been enabled
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  // -------------------------------------------------------------------
  // debug request hold, one more retirement when it came without one
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      rec_dbg_req_q <= 1'b0;
      hold_cnt_q    <= '0;
    end else if (retire_i.valid) begin
      if (debug_req_i) begin
        rec_dbg_req_q <= 1'b1;
        hold_cnt_q    <= HOLD_W'(HOLD);
      end else if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end else begin
        rec_dbg_req_q <= 1'b0;
      end
    end else if (debug_req_i) begin
      rec_dbg_req_q <= 1'b1;
      hold_cnt_q    <= HOLD_W'(HOLD + 1);
    end
  end

  // -------------------------------------------------------------------
  // data request after a taken trap
  // -------------------------------------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      exception_active_q <= 1'b0;
      data_gnt_q         <= 1'b0;
      req_after_exc_q    <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
      if (trap_i.taken) begin
        exception_active_q <= 1'b1;
        if (data_bus_i.req && data_gnt_q) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        exception_active_q <= 1'b0;
        req_after_exc_q    <= 1'b0;
      end else if (exception_active_q && data_gnt_q && data_bus_i.req) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  always_comb begin
    events.first_debug_ins     = retire_i.valid && retire_i.dbg_mode && !dbg_flag_q;
    events.first_fetch         = fetch_enable_i && !fetch_enable_q;
    events.recorded_dbg_req    = rec_dbg_req_q;
    events.req_after_exception = req_after_exc_q;
  end

  assign events_o = events;

endmodule : retire_event_tracker

`default_nettype wire

// File: rtl/sl_macros.svh
// ---------------------------------------------------------------------
// sizing constants for the support logic, included by the package and
// by every module that needs a depth, a count width or a hold count
// ---------------------------------------------------------------------
`ifndef SL_MACROS_SVH
`define SL_MACROS_SVH

// granted but unanswered transactions that one bus may have in flight
`define SL_FIFO_DEPTH 4

// width of an outstanding count, must hold SL_FIFO_DEPTH
`define SL_CNT_W 3

// valid retirements a recorded debug request is held for
`define SL_DBG_HOLD 1

`endif

// File: rtl/sl_pkg.sv
// ---------------------------------------------------------------------
// shared struct types for the support logic: observed bus handshakes,
// the retirement port, trap redirects and the derived status outputs
// ---------------------------------------------------------------------
`default_nettype none

`include "sl_macros.svh"

package sl_pkg;

  // handshake of one OBI bus as seen by the monitors
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } obi_bus_t;

  // retirement stream of the core
  typedef struct packed {
    logic valid;
    logic dbg_mode;
    logic is_dret;
    logic trap;
  } retire_t;

  // set when the pc is redirected to an exception or bus-error trap target
  typedef struct packed {
    logic taken;
  } trap_evt_t;

  // per-bus protocol status
  typedef struct packed {
    logic                 addr_ph_cont;
    logic                 resp_ph_cont;
    logic [`SL_CNT_W-1:0] outstanding;
  } bus_status_t;

  // events derived from the retirement stream
  typedef struct packed {
    logic first_debug_ins;
    logic first_fetch;
    logic recorded_dbg_req;
    logic req_after_exception;
  } retire_events_t;

endpackage : sl_pkg

`default_nettype wire

// File: rtl/support_logic_top.sv
// ---------------------------------------------------------------------
// support logic beside the core: phase monitors and attribute fifos for
// the instruction and data buses plus the retirement event tracker
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module support_logic_top (
  input  wire logic                  in_support_if,
  input  wire logic                  reset_i,

  input  wire sl_pkg::obi_bus_t      instr_bus_i,
  input  wire sl_pkg::obi_bus_t      data_bus_i,
  input  wire logic [31:0]           instr_addr_i,
  input  wire logic                  req_is_store_i,

  input  wire sl_pkg::retire_t       retire_i,
  input  wire sl_pkg::trap_evt_t     trap_i,
  input  wire logic                  fetch_enable_i,
  input  wire logic                  debug_req_i,

  output sl_pkg::bus_status_t        instr_status_o,
  output sl_pkg::bus_status_t        data_status_o,
  output logic [31:0]                instr_resp_addr_o,
  output logic                       data_resp_was_store_o,
  output sl_pkg::retire_events_t     events_o
);

  // -------------------------------------------------------------------
  // bus phase monitors
  // -------------------------------------------------------------------
  obi_phase_monitor u_instr_monitor (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .status_o      (instr_status_o)
  );

  obi_phase_monitor u_data_monitor (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .status_o      (data_status_o)
  );

  // -------------------------------------------------------------------
  // request attributes carried to the responses
  // -------------------------------------------------------------------

  // fetch address of each instruction response
  req_attribute_fifo #(
    .attr_t (logic [31:0])
  ) u_instr_addr_fifo (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_addr_i),
    .attr_o        (instr_resp_addr_o)
  );

  // store flag of each data response
  req_attribute_fifo #(
    .attr_t (logic)
  ) u_store_fifo (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .attr_i        (req_is_store_i),
    .attr_o        (data_resp_was_store_o)
  );

  // -------------------------------------------------------------------
  // retirement events
  // -------------------------------------------------------------------
  retire_event_tracker u_event_tracker (
    .in_support_if  (in_support_if),
    .reset_i        (reset_i),
    .retire_i       (retire_i),
    .trap_i         (trap_i),
    .fetch_enable_i (fetch_enable_i),
    .debug_req_i    (debug_req_i),
    .data_bus_i     (data_bus_i),
    .events_o       (events_o)
  );

endmodule : support_logic_top

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds the support logic testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_support_logic -f all.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation step failed"

cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log 2>/dev/null && exit 0 || exit 1

// File: verification/tb_support_logic.sv
// ----------------------------------------------------------------------
// testbench for the support logic top level, applies a table of inputs
// with random idle gaps and checks every DUT output per cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_support_logic;

  import sl_pkg::*;

  localparam int ROWS = 22;

  // inputs of one cycle and the outputs expected in that cycle
  typedef struct packed {
    obi_bus_t       instr_bus;
    obi_bus_t       data_bus;
    logic [7:0]     addr_tag;
    logic           is_store;
    retire_t        retire;
    logic [2:0]     ctl;
    bus_status_t    instr_status;
    bus_status_t    data_status;
    logic [7:0]     resp_tag;
    logic           resp_store;
    retire_events_t events;
    logic           gap_ok;
  } row_t;

  logic           in_support_if;
  logic           reset_i;
  obi_bus_t       instr_bus;
  obi_bus_t       data_bus;
  logic [31:0]    instr_addr;
  logic           req_is_store;
  retire_t        retire;
  trap_evt_t      trap;
  logic           fetch_enable;
  logic           debug_req;
  bus_status_t    instr_status;
  bus_status_t    data_status;
  logic [31:0]    instr_resp_addr;
  logic           data_resp_was_store;
  retire_events_t events;

  row_t           rows [ROWS];
  int unsigned    gaps [ROWS];
  int             n_rows = 0;
  int             errors = 0;
  int             checks = 0;
  int unsigned    cycles = 0;
  int unsigned    limit;

  support_logic_top uut (
    .in_support_if         (in_support_if),
    .reset_i               (reset_i),
    .instr_bus_i           (instr_bus),
    .data_bus_i            (data_bus),
    .instr_addr_i          (instr_addr),
    .req_is_store_i        (req_is_store),
    .retire_i              (retire),
    .trap_i                (trap),
    .fetch_enable_i        (fetch_enable),
    .debug_req_i           (debug_req),
    .instr_status_o        (instr_status),
    .data_status_o         (data_status),
    .instr_resp_addr_o     (instr_resp_addr),
    .data_resp_was_store_o (data_resp_was_store),
    .events_o              (events)
  );

  initial begin
    in_support_if = 1'b0;
    forever #10 in_support_if = ~in_support_if;
  end

  always @(posedge in_support_if) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: the table did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // table helpers
  // ----------------------------------------------------------------------
  function automatic void add_row(input logic [2:0] ib, input logic [2:0] db,
                                  input logic [7:0] addr, input logic st,
                                  input logic [3:0] ret, input logic [2:0] ctl,
                                  input logic [4:0] is_exp, input logic [4:0] ds_exp,
                                  input logic [7:0] ra, input logic rs,
                                  input logic [3:0] ev, input logic gap);
    rows[n_rows] = {ib, db, addr, st, ret, ctl, is_exp, ds_exp, ra, rs, ev, gap};
    n_rows++;
  endfunction

  task automatic check_value(input int idx, input string what,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
    end
  endtask

  // drive one row on the falling edge, check it before the rising edge
  task automatic apply_row(input int idx);
    row_t r;
    r = rows[idx];
    instr_bus    = r.instr_bus;
    data_bus     = r.data_bus;
    instr_addr   = {4{r.addr_tag}};
    req_is_store = r.is_store;
    retire       = r.retire;
    trap.taken   = r.ctl[2];
    fetch_enable = r.ctl[1];
    debug_req    = r.ctl[0];
    #5;
    check_value(idx, "instr status", 32'(instr_status), 32'(r.instr_status));
    check_value(idx, "data status", 32'(data_status), 32'(r.data_status));
    check_value(idx, "fetch address", instr_resp_addr, {4{r.resp_tag}});
    check_value(idx, "store flag", 32'(data_resp_was_store), 32'(r.resp_store));
    check_value(idx, "events", 32'(events), 32'(r.events));
    @(negedge in_support_if);
  endtask

  // bus codes: 4 req, 2 gnt, 1 rvalid; retire 8 valid, 4 dbg, 2 dret; ctl 4 trap, 2 fe, 1 dbg req
  // status {addr_cont, resp_cont, count}; events 8 first dbg, 4 first fetch, 2 dbg req, 1 after exc
  function automatic void fill_table();
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h0, 1'b1);
    // fetches, stalled data request, stores and loads, debug retirements
    add_row(3'o6, 3'o4, 8'h11, 1'b0, 4'h8, 3'o2, 5'h00, 5'h00, 8'h00, 1'b0, 4'h4, 1'b0);
    add_row(3'o6, 3'o4, 8'h22, 1'b0, 4'h8, 3'o2, 5'h09, 5'h10, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o6, 3'o6, 8'h33, 1'b1, 4'hC, 3'o0, 5'h0A, 5'h10, 8'h00, 1'b0, 4'h8, 1'b0);
    add_row(3'o0, 3'o6, 8'h00, 1'b0, 4'hC, 3'o2, 5'h0B, 5'h09, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o7, 3'o6, 8'h44, 1'b1, 4'hE, 3'o0, 5'h03, 5'h0A, 8'h11, 1'b0, 4'h0, 1'b0);
    add_row(3'o1, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h03, 5'h0B, 8'h22, 1'b0, 4'h0, 1'b0);
    add_row(3'o1, 3'o1, 8'h00, 1'b0, 4'hC, 3'o0, 5'h02, 5'h03, 8'h33, 1'b1, 4'h8, 1'b0);
    add_row(3'o1, 3'o1, 8'h00, 1'b0, 4'h0, 3'o1, 5'h01, 5'h02, 8'h44, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o1, 8'h00, 1'b0, 4'h8, 3'o0, 5'h00, 5'h01, 8'h00, 1'b1, 4'h2, 1'b0);
    // debug request held across idle cycles until the third retirement
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h2, 1'b1);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h8, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h2, 1'b0);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h8, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h2, 1'b0);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h0, 1'b1);
    // trap, granted data cycle, data request, then a clearing retirement
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o4, 5'h00, 5'h00, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o6, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o6, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h09, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h0A, 8'h00, 1'b0, 4'h1, 1'b1);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h8, 3'o0, 5'h00, 5'h0A, 8'h00, 1'b0, 4'h1, 1'b0);
    add_row(3'o0, 3'o1, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h02, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o1, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h01, 8'h00, 1'b0, 4'h0, 1'b0);
    add_row(3'o0, 3'o0, 8'h00, 1'b0, 4'h0, 3'o0, 5'h00, 5'h00, 8'h00, 1'b0, 4'h0, 1'b1);
  endfunction

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned gap_sum;
    reset_i      = 1'b1;
    instr_bus    = '0;
    data_bus     = '0;
    instr_addr   = '0;
    req_is_store = 1'b0;
    retire       = '0;
    trap         = '0;
    fetch_enable = 1'b0;
    debug_req    = 1'b0;
    void'($urandom(61));
    fill_table();
    gap_sum = 0;
    // idle gaps only follow quiet rows, so they repeat that row
    for (int i = 0; i < ROWS; i++) begin
      gaps[i] = rows[i].gap_ok ? ($urandom % 4) : 0;
      gap_sum += gaps[i];
    end
    limit = ROWS + gap_sum + 20;
    repeat (3) @(posedge in_support_if);
    @(negedge in_support_if);
    reset_i = 1'b0;
    for (int i = 0; i < ROWS; i++) begin
      apply_row(i);
      repeat (gaps[i]) apply_row(i);
    end
    $display("summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_support_logic

`default_nettype wire
